//--- filelist.f
periph_pkg.sv
periph_reg_if.sv
periph_decoder.sv
periph_timer.sv
periph_plic.sv
periph_top.sv
tb_periph.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_periph
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_periph.sv
module tb_periph;
    import periph_pkg::*;

    localparam int ClkPeriod      = 20;
    localparam int ResetCycles    = 10;
    localparam int InputDelay     = 2;
    // Accept edge, two latency edges and a few held cycles per access
    localparam int NumAccesses    = 64;
    localparam int AccessCycles   = 6;
    localparam int ExpectedCycles = ResetCycles + NumAccesses * AccessCycles + 40;
    localparam int TimeoutCycles  = 4 * ExpectedCycles;

    logic                 clk_i;
    logic                 reset_i;
    logic                 req_valid_i;
    logic                 req_ready_o;
    logic                 req_write_i;
    addr_t                req_addr_i;
    data_t                req_wdata_i;
    logic                 rsp_valid_o;
    logic                 rsp_ready_i;
    data_t                rsp_rdata_o;
    logic                 rsp_err_o;
    logic [NumExtIrq-1:0] ext_irq_i;
    logic                 irq_o;

    int seed        = 7;
    int cycle_count = 0;

    // Reference model of the register state
    prio_t    mdl_prio [NumSources];
    src_vec_t mdl_enable;
    prio_t    mdl_threshold;
    src_vec_t mdl_claimed;
    src_vec_t mdl_src;

    periph_top uut (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .req_valid_i ( req_valid_i ),
        .req_ready_o ( req_ready_o ),
        .req_write_i ( req_write_i ),
        .req_addr_i  ( req_addr_i  ),
        .req_wdata_i ( req_wdata_i ),
        .rsp_valid_o ( rsp_valid_o ),
        .rsp_ready_i ( rsp_ready_i ),
        .rsp_rdata_o ( rsp_rdata_o ),
        .rsp_err_o   ( rsp_err_o   ),
        .ext_irq_i   ( ext_irq_i   ),
        .irq_o       ( irq_o       )
    );

    initial begin
        clk_i = 1'b0;
        forever #(ClkPeriod / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TimeoutCycles) begin
            fail_run("run did not finish within the cycle limit");
        end
    end

    // --------------------------------------------------
    // Checking helpers
    // --------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input data_t got, input data_t exp);
        assert (got === exp) else begin
            fail_run($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            fail_run(what);
        end
    endtask

    function automatic addr_t reg_addr(input int region, input int word);
        return addr_t'((region << RegionLsb) | (word << OffsetLsb));
    endfunction

    // Best eligible source plus one or zero when nothing is eligible
    function automatic int expected_claim();
        int    best;
        prio_t best_prio;
        best      = -1;
        best_prio = '0;
        for (int i = 0; i < NumSources; i++) begin
            if (mdl_src[i] && !mdl_claimed[i] && mdl_enable[i]
                && (mdl_prio[i] > mdl_threshold)) begin
                if ((best < 0) || (mdl_prio[i] > best_prio)) begin
                    best      = i;
                    best_prio = mdl_prio[i];
                end
            end
        end
        return best + 1;
    endfunction

    // --------------------------------------------------
    // Bus tasks
    // --------------------------------------------------
    task automatic step();
        @(posedge clk_i);
        #InputDelay;
    endtask

    task automatic access(input logic write, input addr_t addr, input data_t wdata,
                          output data_t rdata, output logic err);
        data_t held_rdata;
        logic  held_err;
        logic  taken;
        req_valid_i = 1'b1;
        req_write_i = write;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        while (!req_ready_o) begin
            step();
        end
        step();
        req_valid_i = 1'b0;
        check_value("req_ready_o", data_t'(req_ready_o), '0);
        step();
        check_value("rsp_valid_o", data_t'(rsp_valid_o), '0);
        step();
        check_value("rsp_valid_o", data_t'(rsp_valid_o), 32'h1);
        held_rdata = rsp_rdata_o;
        held_err   = rsp_err_o;
        taken      = 1'b0;
        // Random ready gives back-pressure on some responses
        while (!taken) begin
            rsp_ready_i = ($random(seed) & 1) != 0;
            taken       = rsp_ready_i;
            step();
            if (!taken) begin
                check_value("rsp_valid_o", data_t'(rsp_valid_o), 32'h1);
                check_value("rsp_rdata_o", rsp_rdata_o, held_rdata);
                check_value("rsp_err_o", data_t'(rsp_err_o), data_t'(held_err));
            end
        end
        rsp_ready_i = 1'b0;
        check_value("rsp_valid_o", data_t'(rsp_valid_o), '0);
        check_value("req_ready_o", data_t'(req_ready_o), 32'h1);
        rdata = held_rdata;
        err   = held_err;
    endtask

    task automatic write_reg(input addr_t addr, input data_t wdata);
        data_t rdata;
        logic  err;
        access(1'b1, addr, wdata, rdata, err);
        check_value("rsp_err_o", data_t'(err), '0);
        check_value("rsp_rdata_o", rdata, '0);
    endtask

    task automatic read_reg(input addr_t addr, output data_t rdata);
        logic err;
        access(1'b0, addr, '0, rdata, err);
        check_value("rsp_err_o", data_t'(err), '0);
    endtask

    task automatic read_check(input addr_t addr, input data_t exp);
        data_t rdata;
        read_reg(addr, rdata);
        check_value("rsp_rdata_o", rdata, exp);
    endtask

    task automatic expect_error(input logic write, input addr_t addr, input logic unmapped);
        data_t rdata;
        logic  err;
        access(write, addr, 32'h0000_00a5, rdata, err);
        check_value("rsp_err_o", data_t'(err), 32'h1);
        if (unmapped) begin
            check_value("rsp_rdata_o", rdata, ErrPattern);
        end
    endtask

    task automatic set_prio(input int idx, input prio_t prio);
        write_reg(reg_addr(RegionPlic, PlicPrioBase + idx), data_t'(prio));
        mdl_prio[idx] = prio;
    endtask

    task automatic claim_check();
        int exp_id;
        exp_id = expected_claim();
        read_check(reg_addr(RegionPlic, PlicClaim), data_t'(exp_id));
        if (exp_id != 0) begin
            mdl_claimed[exp_id - 1] = 1'b1;
        end
    endtask

    task automatic complete(input int id);
        write_reg(reg_addr(RegionPlic, PlicClaim), data_t'(id));
        mdl_claimed[id - 1] = 1'b0;
    endtask

    // irq_o is registered, so give it an edge to follow
    task automatic irq_check();
        step();
        step();
        check_value("irq_o", data_t'(irq_o), data_t'(expected_claim() != 0));
    endtask

    task automatic set_ext(input logic [NumExtIrq-1:0] lines);
        ext_irq_i = lines;
        mdl_src   = {1'b0, lines};
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        data_t rdata;
        data_t count0;
        data_t count1;
        logic  found;
        int    polls;
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        rsp_ready_i = 1'b0;
        ext_irq_i   = '0;
        for (int i = 0; i < NumSources; i++) begin
            mdl_prio[i] = '0;
        end
        mdl_enable    = '0;
        mdl_threshold = '0;
        mdl_claimed   = '0;
        mdl_src       = '0;
        repeat (ResetCycles) @(posedge clk_i);
        #InputDelay;
        reset_i = 1'b0;

        // Idle state straight after reset
        check_value("req_ready_o", data_t'(req_ready_o), 32'h1);
        check_value("rsp_valid_o", data_t'(rsp_valid_o), '0);
        check_value("irq_o", data_t'(irq_o), '0);

        // Register readback
        for (int i = 0; i < NumSources; i++) begin
            set_prio(i, prio_t'(i + 1));
            read_check(reg_addr(RegionPlic, PlicPrioBase + i), data_t'(i + 1));
        end
        write_reg(reg_addr(RegionPlic, PlicEnable), 32'h5);
        read_check(reg_addr(RegionPlic, PlicEnable), 32'h5);
        write_reg(reg_addr(RegionPlic, PlicThreshold), 32'h2);
        read_check(reg_addr(RegionPlic, PlicThreshold), 32'h2);
        write_reg(reg_addr(RegionTimer, TimerCompare), 32'h1234_5678);
        read_check(reg_addr(RegionTimer, TimerCompare), 32'h1234_5678);
        write_reg(reg_addr(RegionTimer, TimerCtrl), 32'h1);
        read_check(reg_addr(RegionTimer, TimerCtrl), 32'h1);
        write_reg(reg_addr(RegionTimer, TimerCtrl), 32'h0);
        read_check(reg_addr(RegionTimer, TimerCtrl), 32'h0);
        write_reg(reg_addr(RegionPlic, PlicEnable), 32'h0);
        write_reg(reg_addr(RegionPlic, PlicThreshold), 32'h0);
        for (int i = 0; i < NumSources; i++) begin
            set_prio(i, '0);
        end

        // Error replies
        expect_error(1'b0, 16'h2000, 1'b1);
        expect_error(1'b1, 16'hf00c, 1'b1);
        expect_error(1'b0, 16'h7ff0, 1'b1);
        expect_error(1'b0, reg_addr(RegionPlic, 7), 1'b0);
        expect_error(1'b1, reg_addr(RegionTimer, 3), 1'b0);
        expect_error(1'b1, reg_addr(RegionPlic, PlicPending), 1'b0);

        // Timer count and interrupt
        write_reg(reg_addr(RegionTimer, TimerCount), 32'h0);
        read_check(reg_addr(RegionTimer, TimerCount), 32'h0);
        write_reg(reg_addr(RegionTimer, TimerCompare), 32'h4);
        write_reg(reg_addr(RegionTimer, TimerCtrl), 32'h1);
        found = 1'b0;
        polls = 0;
        while (!found && (polls < 10)) begin
            read_reg(reg_addr(RegionPlic, PlicPending), rdata);
            found = rdata[TimerSource];
            polls++;
        end
        check_true(found, "timer pending bit never set");
        read_reg(reg_addr(RegionTimer, TimerCount), count0);
        read_reg(reg_addr(RegionTimer, TimerCount), count1);
        check_true(count1 >= count0, "timer count went backwards");
        write_reg(reg_addr(RegionTimer, TimerCtrl), 32'h0);

        // Claim and complete on the external lines
        set_prio(0, 2'd1);
        set_prio(1, 2'd3);
        write_reg(reg_addr(RegionPlic, PlicEnable), 32'h3);
        mdl_enable = 3'b011;
        set_ext(2'b11);
        irq_check();
        claim_check();
        claim_check();
        claim_check();
        irq_check();
        complete(2);
        complete(1);
        irq_check();

        // Threshold and enable mask
        write_reg(reg_addr(RegionPlic, PlicThreshold), 32'h3);
        mdl_threshold = 2'd3;
        irq_check();
        claim_check();
        write_reg(reg_addr(RegionPlic, PlicThreshold), 32'h0);
        mdl_threshold = 2'd0;
        irq_check();
        write_reg(reg_addr(RegionPlic, PlicEnable), 32'h0);
        mdl_enable = '0;
        irq_check();
        claim_check();
        set_ext(2'b00);

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- periph_top.sv
module periph_top (
    input  logic                             clk_i,
    input  logic                             reset_i,
    // Request channel
    input  logic                             req_valid_i,
    output logic                             req_ready_o,
    input  logic                             req_write_i,
    input  periph_pkg::addr_t                req_addr_i,
    input  periph_pkg::data_t                req_wdata_i,
    // Response channel
    output logic                             rsp_valid_o,
    input  logic                             rsp_ready_i,
    output periph_pkg::data_t                rsp_rdata_o,
    output logic                             rsp_err_o,
    // Interrupts
    input  logic [periph_pkg::NumExtIrq-1:0] ext_irq_i,
    output logic                             irq_o
);
    import periph_pkg::*;

    logic     timer_irq;
    src_vec_t irq_src;

    periph_reg_if plic_bus ();
    periph_reg_if timer_bus ();

    // External lines first, timer on the last source
    assign irq_src[NumExtIrq-1:0] = ext_irq_i;
    assign irq_src[TimerSource]   = timer_irq;

    periph_decoder i_decoder (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .req_valid_i ( req_valid_i ),
        .req_ready_o ( req_ready_o ),
        .req_write_i ( req_write_i ),
        .req_addr_i  ( req_addr_i  ),
        .req_wdata_i ( req_wdata_i ),
        .rsp_valid_o ( rsp_valid_o ),
        .rsp_ready_i ( rsp_ready_i ),
        .rsp_rdata_o ( rsp_rdata_o ),
        .rsp_err_o   ( rsp_err_o   ),
        .plic_bus    ( plic_bus    ),
        .timer_bus   ( timer_bus   )
    );

    periph_timer i_timer (
        .clk_i   ( clk_i     ),
        .reset_i ( reset_i   ),
        .bus     ( timer_bus ),
        .irq_o   ( timer_irq )
    );

    periph_plic i_plic (
        .clk_i   ( clk_i    ),
        .reset_i ( reset_i  ),
        .bus     ( plic_bus ),
        .src_i   ( irq_src  ),
        .irq_o   ( irq_o    )
    );

endmodule

//--- periph_plic.sv
module periph_plic (
    input  logic                  clk_i,
    input  logic                  reset_i,
    periph_reg_if.slave           bus,
    input  periph_pkg::src_vec_t  src_i,
    output logic                  irq_o
);
    import periph_pkg::*;

    prio_t                 prio_q [NumSources];
    src_vec_t              enable_q;
    prio_t                 threshold_q;
    src_vec_t              claimed_q;
    logic                  irq_q;

    src_vec_t              pending;
    src_vec_t              eligible;
    logic                  best_found;
    prio_t                 best_prio;
    logic [ClaimWidth-1:0] best_idx;
    logic [ClaimWidth-1:0] claim_id;

    logic [NumSources-1:0] prio_sel;
    data_t                 prio_rd;
    logic                  hit;
    data_t                 rd_val;
    logic                  acc_err;
    logic                  claim_rd;
    logic                  complete_wr;
    logic                  complete_ok;
    logic [ClaimWidth-1:0] complete_id;

    logic                  done_q;
    data_t                 rdata_q;
    logic                  err_q;

    function automatic prio_t clamp_prio(data_t value);
        if (value > data_t'(MaxPriority)) begin
            return prio_t'(MaxPriority);
        end
        return prio_t'(value);
    endfunction

    // ------------------------------------------------
    // Source arbitration
    // ------------------------------------------------
    assign pending = src_i & ~claimed_q;

    always_comb begin
        best_found = 1'b0;
        best_prio  = '0;
        best_idx   = '0;
        for (int i = 0; i < NumSources; i++) begin
            eligible[i] = pending[i] && enable_q[i] && (prio_q[i] > threshold_q);
            // Strict compare keeps the lower index on a tie
            if (eligible[i] && (!best_found || (prio_q[i] > best_prio))) begin
                best_found = 1'b1;
                best_prio  = prio_q[i];
                best_idx   = ClaimWidth'(i);
            end
        end
    end

    assign claim_id = best_found ? ClaimWidth'(best_idx + 1'b1) : '0;

    // ------------------------------------------------
    // Register decode
    // ------------------------------------------------
    always_comb begin
        prio_rd = '0;
        for (int i = 0; i < NumSources; i++) begin
            prio_sel[i] = (bus.offset == offset_t'(PlicPrioBase + i));
            if (prio_sel[i]) begin
                prio_rd = data_t'(prio_q[i]);
            end
        end
    end

    always_comb begin
        hit    = 1'b1;
        rd_val = '0;
        case (bus.offset)
            PlicPending:   rd_val = data_t'(pending);
            PlicEnable:    rd_val = data_t'(enable_q);
            PlicThreshold: rd_val = data_t'(threshold_q);
            PlicClaim:     rd_val = data_t'(claim_id);
            default: begin
                hit    = |prio_sel;
                rd_val = prio_rd;
            end
        endcase
    end

    assign claim_rd    = bus.valid && !bus.write && (bus.offset == PlicClaim);
    assign complete_wr = bus.valid && bus.write && (bus.offset == PlicClaim);
    assign complete_ok = (bus.wdata != '0) && (bus.wdata <= data_t'(NumSources));
    assign complete_id = bus.wdata[ClaimWidth-1:0];

    // Pending is read-only and a complete must name a real source
    assign acc_err = !hit
                  || (bus.write && (bus.offset == PlicPending))
                  || (bus.write && (bus.offset == PlicClaim) && !complete_ok);

    // ------------------------------------------------
    // Register state
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NumSources; i++) begin
                prio_q[i] <= '0;
            end
            enable_q    <= '0;
            threshold_q <= '0;
            claimed_q   <= '0;
            irq_q       <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            done_q <= bus.valid;
            irq_q  <= |eligible;
            if (bus.valid && bus.write && (bus.offset == PlicEnable)) begin
                enable_q <= src_vec_t'(bus.wdata);
            end
            if (bus.valid && bus.write && (bus.offset == PlicThreshold)) begin
                threshold_q <= clamp_prio(bus.wdata);
            end
            for (int i = 0; i < NumSources; i++) begin
                if (bus.valid && bus.write && prio_sel[i]) begin
                    prio_q[i] <= clamp_prio(bus.wdata);
                end
                if (claim_rd && best_found && (best_idx == ClaimWidth'(i))) begin
                    claimed_q[i] <= 1'b1;
                end else if (complete_wr && complete_ok
                             && (complete_id == ClaimWidth'(i + 1))) begin
                    claimed_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus.valid) begin
            err_q <= acc_err;
            if (acc_err) begin
                rdata_q <= ErrPattern;
            end else if (bus.write) begin
                rdata_q <= '0;
            end else begin
                rdata_q <= rd_val;
            end
        end
    end

    assign bus.done  = done_q;
    assign bus.rdata = rdata_q;
    assign bus.err   = err_q;
    assign irq_o     = irq_q;

endmodule

//--- periph_timer.sv
module periph_timer (
    input  logic         clk_i,
    input  logic         reset_i,
    periph_reg_if.slave  bus,
    output logic         irq_o
);
    import periph_pkg::*;

    data_t count_q;
    data_t compare_q;
    logic  enable_q;

    logic  hit;
    data_t rd_val;
    logic  acc_err;
    logic  wr_count;
    logic  wr_compare;
    logic  wr_ctrl;

    logic  done_q;
    data_t rdata_q;
    logic  err_q;

    // ------------------------------------------------
    // Register decode
    // ------------------------------------------------
    always_comb begin
        hit    = 1'b1;
        rd_val = '0;
        case (bus.offset)
            TimerCount:   rd_val = count_q;
            TimerCompare: rd_val = compare_q;
            TimerCtrl:    rd_val = data_t'(enable_q);
            default:      hit = 1'b0;
        endcase
    end

    assign acc_err    = !hit;
    assign wr_count   = bus.valid && bus.write && (bus.offset == TimerCount);
    assign wr_compare = bus.valid && bus.write && (bus.offset == TimerCompare);
    assign wr_ctrl    = bus.valid && bus.write && (bus.offset == TimerCtrl);

    // ------------------------------------------------
    // Timer state
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q   <= '0;
            compare_q <= '0;
            enable_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= bus.valid;
            // A software load takes priority over counting
            if (wr_count) begin
                count_q <= bus.wdata;
            end else if (enable_q) begin
                count_q <= count_q + 1'b1;
            end
            if (wr_compare) begin
                compare_q <= bus.wdata;
            end
            if (wr_ctrl) begin
                enable_q <= bus.wdata[0];
            end
        end
    end

    // Reply payload where writes read back as zero
    always_ff @(posedge clk_i) begin
        if (bus.valid) begin
            err_q <= acc_err;
            if (acc_err) begin
                rdata_q <= ErrPattern;
            end else if (bus.write) begin
                rdata_q <= '0;
            end else begin
                rdata_q <= rd_val;
            end
        end
    end

    assign bus.done  = done_q;
    assign bus.rdata = rdata_q;
    assign bus.err   = err_q;

    // Level interrupt while the count has reached compare
    assign irq_o = enable_q && (count_q >= compare_q);

endmodule

//--- periph_decoder.sv
module periph_decoder (
    input  logic               clk_i,
    input  logic               reset_i,
    // Request channel
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  logic               req_write_i,
    input  periph_pkg::addr_t  req_addr_i,
    input  periph_pkg::data_t  req_wdata_i,
    // Response channel
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output periph_pkg::data_t  rsp_rdata_o,
    output logic               rsp_err_o,
    // Peripheral buses
    periph_reg_if.master       plic_bus,
    periph_reg_if.master       timer_bus
);
    import periph_pkg::*;

    typedef enum logic [1:0] {
        StIdle,
        StWait,
        StHold
    } state_e;

    state_e  state_q;
    logic    accept;
    region_t region;

    // Captured request
    logic    write_q;
    offset_t offset_q;
    data_t   wdata_q;

    // Per-target valid pulses with the error path acting as a third slave
    logic    plic_valid_q;
    logic    timer_valid_q;
    logic    err_valid_q;
    logic    err_done_q;

    logic    reply_done;
    data_t   reply_rdata;
    logic    reply_err;

    data_t   rsp_rdata_q;
    logic    rsp_err_q;

    assign region = req_addr_i[RegionLsb +: RegionWidth];
    assign accept = req_valid_i && req_ready_o;

    // ------------------------------------------------
    // Handshake FSM
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q       <= StIdle;
            plic_valid_q  <= 1'b0;
            timer_valid_q <= 1'b0;
            err_valid_q   <= 1'b0;
            err_done_q    <= 1'b0;
        end else begin
            plic_valid_q  <= 1'b0;
            timer_valid_q <= 1'b0;
            err_valid_q   <= 1'b0;
            // Unmapped access answers one cycle later just like a slave
            err_done_q    <= err_valid_q;
            case (state_q)
                StIdle: begin
                    if (accept) begin
                        state_q       <= StWait;
                        plic_valid_q  <= (region == RegionPlic);
                        timer_valid_q <= (region == RegionTimer);
                        err_valid_q   <= (region != RegionPlic) && (region != RegionTimer);
                    end
                end
                StWait: begin
                    if (reply_done) begin
                        state_q <= StHold;
                    end
                end
                StHold: begin
                    if (rsp_ready_i) begin
                        state_q <= StIdle;
                    end
                end
                default: state_q <= StIdle;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            write_q  <= req_write_i;
            offset_q <= req_addr_i[OffsetLsb +: OffsetWidth];
            wdata_q  <= req_wdata_i;
        end
        if ((state_q == StWait) && reply_done) begin
            rsp_rdata_q <= reply_rdata;
            rsp_err_q   <= reply_err;
        end
    end

    // ------------------------------------------------
    // Reply select
    // ------------------------------------------------
    assign reply_done = plic_bus.done || timer_bus.done || err_done_q;

    always_comb begin
        if (plic_bus.done) begin
            reply_rdata = plic_bus.rdata;
            reply_err   = plic_bus.err;
        end else if (timer_bus.done) begin
            reply_rdata = timer_bus.rdata;
            reply_err   = timer_bus.err;
        end else begin
            reply_rdata = ErrPattern;
            reply_err   = 1'b1;
        end
    end

    // Both buses share the captured request fields
    assign plic_bus.valid   = plic_valid_q;
    assign plic_bus.write   = write_q;
    assign plic_bus.offset  = offset_q;
    assign plic_bus.wdata   = wdata_q;

    assign timer_bus.valid  = timer_valid_q;
    assign timer_bus.write  = write_q;
    assign timer_bus.offset = offset_q;
    assign timer_bus.wdata  = wdata_q;

    assign req_ready_o = (state_q == StIdle);
    assign rsp_valid_o = (state_q == StHold);
    assign rsp_rdata_o = rsp_rdata_q;
    assign rsp_err_o   = rsp_err_q;

endmodule

//--- periph_reg_if.sv
// One register access from the decoder to a peripheral
interface periph_reg_if;
    import periph_pkg::*;

    // Request with a single-cycle valid pulse
    logic    valid;
    logic    write;
    offset_t offset;
    data_t   wdata;

    // Reply with done one cycle after valid
    logic    done;
    data_t   rdata;
    logic    err;

    modport master (
        output valid,
        output write,
        output offset,
        output wdata,
        input  done,
        input  rdata,
        input  err
    );

    modport slave (
        input  valid,
        input  write,
        input  offset,
        input  wdata,
        output done,
        output rdata,
        output err
    );

endinterface

//--- periph_pkg.sv
package periph_pkg;

    // ------------------------------------------------
    // Bus widths
    // ------------------------------------------------
    localparam int AddrWidth = 16;
    localparam int DataWidth = 32;

    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [DataWidth-1:0] data_t;

    // ------------------------------------------------
    // Address map
    // ------------------------------------------------
    // Region field sits in the top address bits
    localparam int RegionLsb   = 12;
    localparam int RegionWidth = AddrWidth - RegionLsb;

    typedef logic [RegionWidth-1:0] region_t;

    localparam region_t RegionPlic  = 'd0;
    localparam region_t RegionTimer = 'd1;

    // Word offset inside a region
    localparam int OffsetLsb   = 2;
    localparam int OffsetWidth = 4;

    typedef logic [OffsetWidth-1:0] offset_t;

    // Read data returned with any error reply
    localparam data_t ErrPattern = 32'hdeadbeef;

    // ------------------------------------------------
    // Interrupts
    // ------------------------------------------------
    localparam int NumExtIrq   = 2;
    localparam int NumSources  = 3;
    localparam int TimerSource = 2;
    localparam int MaxPriority = 3;
    // Claim IDs are source index plus one, zero means none
    localparam int ClaimWidth  = $clog2(NumSources + 1);

    typedef logic [1:0]            prio_t;
    typedef logic [NumSources-1:0] src_vec_t;

    // Interrupt controller register words
    localparam offset_t PlicPending   = 'd0;
    localparam offset_t PlicEnable    = 'd1;
    localparam offset_t PlicThreshold = 'd2;
    localparam offset_t PlicClaim     = 'd3;
    localparam offset_t PlicPrioBase  = 'd4;

    // Timer register words
    localparam offset_t TimerCount   = 'd0;
    localparam offset_t TimerCompare = 'd1;
    localparam offset_t TimerCtrl    = 'd2;

endpackage
